/* hdl/uart_frame_pkg.sv */
package uart_frame_pkg;

   // ==========================================================
   // frame layout
   // ==========================================================

   // one frame: start 0, data msb first, odd parity, stop 1.
   localparam int data_bits  = 8;   // payload bits per frame.
   localparam int frame_bits = 11;  // start + data + parity + stop.

   // ==========================================================
   // receive result
   // ==========================================================

   // stop error wins over parity error when both are seen.
   typedef enum logic [1:0] {
      rx_ok,          // good parity, stop bit high.
      rx_parity_err,  // ones count over data and parity is even.
      rx_stop_err     // stop bit sampled low.
   } rx_status_e;

endpackage

/* hdl/uart_ctrl_pkg.sv */
package uart_ctrl_pkg;

   // ==========================================================
   // control sequencer states
   // ==========================================================

   // command side, one command is two frames.
   typedef enum logic [1:0] {
      tx_idle,  // waiting for cmd_req.
      tx_high,  // high byte loaded or on the line.
      tx_low,   // low byte loaded or on the line.
      tx_ack    // cmd_ack held until cmd_req drops.
   } tx_state_e;

   // read side, four-phase toward the reader.
   typedef enum logic [1:0] {
      rd_idle,         // free to take a byte.
      rd_req,          // read_req high, waiting for read_ack.
      rd_wait_release  // waiting for read_ack low.
   } rx_state_e;

endpackage

/* hdl/uart_tx_serializer.sv */
`timescale 1ns/10ps

module uart_tx_serializer #(
   parameter int clks_per_bit = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       load,
   input  logic [7:0] tx_byte,
   output logic       busy,
   output logic       done,
   output logic       tx
);

   localparam int tick_w = $clog2(clks_per_bit);
   localparam int idx_w  = $clog2(uart_frame_pkg::frame_bits);

   localparam logic [tick_w-1:0] tick_last = tick_w'(clks_per_bit - 1);
   localparam logic [idx_w-1:0]  idx_stop  = idx_w'(uart_frame_pkg::frame_bits - 1);

   // data, parity and stop still waiting to go out; start goes straight to tx.
   logic [uart_frame_pkg::data_bits+1:0] shreg;
   logic [tick_w-1:0]                    tick;
   logic [idx_w-1:0]                     bit_idx;
   logic                                 bit_end;

   assign bit_end = busy && (tick == tick_last);        // last clock of current bit.
   assign done    = bit_end && (bit_idx == idx_stop);   // last clock of stop bit.

   // ==========================================================
   // bit timing and line driver
   // ==========================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         tx      <= 1'b1;
         tick    <= '0;
         bit_idx <= '0;
      end else if (load) begin
         busy    <= 1'b1;
         tx      <= 1'b0;                               // start bit.
         tick    <= '0;
         bit_idx <= '0;
      end else if (busy) begin
         if (bit_end) begin
            tick <= '0;
            if (bit_idx == idx_stop) begin
               busy <= 1'b0;
               tx   <= 1'b1;                            // back to idle level.
            end else begin
               bit_idx <= bit_idx + 1'b1;
               tx      <= shreg[uart_frame_pkg::data_bits+1];
            end
         end else begin
            tick <= tick + 1'b1;
         end
      end
   end

   // ==========================================================
   // frame shift register
   // ==========================================================

   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= {tx_byte, ~^tx_byte, 1'b1};          // odd parity over the byte.
      end else if (bit_end) begin
         shreg <= {shreg[uart_frame_pkg::data_bits:0], 1'b1};
      end
   end

endmodule

/* hdl/uart_rx_deserializer.sv */
`timescale 1ns/10ps

module uart_rx_deserializer #(
   parameter int clks_per_bit = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       rx,
   output logic                       byte_valid,
   output logic [7:0]                 rx_byte,
   output uart_frame_pkg::rx_status_e rx_status
);

   localparam int tick_w = $clog2(clks_per_bit);
   localparam int idx_w  = $clog2(uart_frame_pkg::frame_bits);

   localparam logic [tick_w-1:0] tick_last  = tick_w'(clks_per_bit - 1);
   localparam logic [tick_w-1:0] tick_mid   = tick_w'(clks_per_bit / 2);
   localparam logic [idx_w-1:0]  idx_parity = idx_w'(uart_frame_pkg::data_bits + 1);
   localparam logic [idx_w-1:0]  idx_stop   = idx_w'(uart_frame_pkg::frame_bits - 1);

   logic                                 rx_meta;
   logic                                 rx_sync;
   logic                                 rx_prev;
   logic                                 start_edge;
   logic                                 active;
   logic                                 sample;
   logic [tick_w-1:0]                    tick;
   logic [idx_w-1:0]                     bit_idx;
   logic [uart_frame_pkg::data_bits-1:0] shreg;
   logic                                 par_bit;

   // ==========================================================
   // line synchronizer and start detect
   // ==========================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign start_edge = rx_prev & ~rx_sync;
   assign sample     = active && (tick == tick_mid);    // middle of the current bit.

   // ==========================================================
   // bit timing
   // ==========================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active  <= 1'b0;
         tick    <= '0;
         bit_idx <= '0;
      end else if (!active) begin
         if (start_edge) begin
            active  <= 1'b1;
            tick    <= tick_w'(1);                      // edge cycle counts as clock 0.
            bit_idx <= '0;
         end
      end else begin
         tick <= (tick == tick_last) ? '0 : tick + 1'b1;
         if (sample) begin
            if ((bit_idx == '0) && rx_sync) begin
               active <= 1'b0;                          // false start, glitch on the line.
            end else if (bit_idx == idx_stop) begin
               active <= 1'b0;
            end else begin
               bit_idx <= bit_idx + 1'b1;
            end
         end
      end
   end

   // ==========================================================
   // data capture
   // ==========================================================

   always_ff @(posedge clk) begin
      if (sample) begin
         if ((bit_idx != '0) && (bit_idx < idx_parity)) begin
            shreg <= {shreg[uart_frame_pkg::data_bits-2:0], rx_sync};   // msb first.
         end
         if (bit_idx == idx_parity) begin
            par_bit <= rx_sync;
         end
      end
   end

   assign byte_valid = sample && (bit_idx == idx_stop);
   assign rx_byte    = shreg;

   // rx_sync here is the stop bit sample.
   always_comb begin
      if (!rx_sync) begin
         rx_status = uart_frame_pkg::rx_stop_err;
      end else if (!(^{shreg, par_bit})) begin
         rx_status = uart_frame_pkg::rx_parity_err;
      end else begin
         rx_status = uart_frame_pkg::rx_ok;
      end
   end

endmodule

/* hdl/uart_link_ctrl.sv */
`timescale 1ns/10ps

module uart_link_ctrl (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [15:0]                cmd_data,
   input  logic                       cmd_req,
   output logic                       cmd_ack,
   output logic                       load,
   output logic [7:0]                 tx_byte,
   input  logic                       busy,
   input  logic                       done,
   input  logic                       byte_valid,
   input  logic [7:0]                 rx_byte,
   input  uart_frame_pkg::rx_status_e rx_status,
   output logic [7:0]                 read_data,
   output uart_frame_pkg::rx_status_e read_status,
   output logic                       read_req,
   input  logic                       read_ack,
   output logic                       read_overrun
);

   uart_ctrl_pkg::tx_state_e tx_state;
   uart_ctrl_pkg::rx_state_e rd_state;
   logic [15:0]              cmd_q;
   logic                     load_pend;

   // ==========================================================
   // command sequencer
   // ==========================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_state  <= uart_ctrl_pkg::tx_idle;
         load_pend <= 1'b0;
      end else begin
         if (load) begin
            load_pend <= 1'b0;
         end
         case (tx_state)
            uart_ctrl_pkg::tx_idle: begin
               if (cmd_req) begin
                  tx_state  <= uart_ctrl_pkg::tx_high;
                  load_pend <= 1'b1;
               end
            end
            uart_ctrl_pkg::tx_high: begin
               if (done) begin
                  tx_state  <= uart_ctrl_pkg::tx_low;
                  load_pend <= 1'b1;                    // low byte right behind the high one.
               end
            end
            uart_ctrl_pkg::tx_low: begin
               if (done) begin
                  tx_state <= uart_ctrl_pkg::tx_ack;
               end
            end
            uart_ctrl_pkg::tx_ack: begin
               if (!cmd_req) begin
                  tx_state <= uart_ctrl_pkg::tx_idle;
               end
            end
            default: tx_state <= uart_ctrl_pkg::tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((tx_state == uart_ctrl_pkg::tx_idle) && cmd_req) begin
         cmd_q <= cmd_data;
      end
   end

   assign load    = load_pend & ~busy;
   assign tx_byte = (tx_state == uart_ctrl_pkg::tx_high) ? cmd_q[15:8] : cmd_q[7:0];
   assign cmd_ack = (tx_state == uart_ctrl_pkg::tx_ack);

   // ==========================================================
   // read handshake
   // ==========================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_state     <= uart_ctrl_pkg::rd_idle;
         read_overrun <= 1'b0;
      end else begin
         if (byte_valid && (rd_state != uart_ctrl_pkg::rd_idle)) begin
            read_overrun <= 1'b1;                       // sticky, new byte is lost.
         end
         case (rd_state)
            uart_ctrl_pkg::rd_idle: begin
               if (byte_valid) begin
                  rd_state <= uart_ctrl_pkg::rd_req;
               end
            end
            uart_ctrl_pkg::rd_req: begin
               if (read_ack) begin
                  rd_state <= uart_ctrl_pkg::rd_wait_release;
               end
            end
            uart_ctrl_pkg::rd_wait_release: begin
               if (!read_ack) begin
                  rd_state <= uart_ctrl_pkg::rd_idle;
               end
            end
            default: rd_state <= uart_ctrl_pkg::rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((rd_state == uart_ctrl_pkg::rd_idle) && byte_valid) begin
         read_data   <= rx_byte;
         read_status <= rx_status;
      end
   end

   assign read_req = (rd_state == uart_ctrl_pkg::rd_req);

endmodule

/* hdl/uart_link.sv */
`timescale 1ns/10ps

module uart_link #(
   parameter int clks_per_bit = 4                       // line bit time in clocks, 2 or more.
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [15:0]                cmd_data,
   input  logic                       cmd_req,
   output logic                       cmd_ack,
   input  logic                       rx,
   output logic                       tx,
   output logic [7:0]                 read_data,
   output uart_frame_pkg::rx_status_e read_status,
   output logic                       read_req,
   input  logic                       read_ack,
   output logic                       read_overrun
);

   logic                       load;
   logic [7:0]                 tx_byte;
   logic                       busy;
   logic                       done;
   logic                       byte_valid;
   logic [7:0]                 rx_byte;
   uart_frame_pkg::rx_status_e rx_status;

   uart_link_ctrl i_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_data     (cmd_data),
      .cmd_req      (cmd_req),
      .cmd_ack      (cmd_ack),
      .load         (load),
      .tx_byte      (tx_byte),
      .busy         (busy),
      .done         (done),
      .byte_valid   (byte_valid),
      .rx_byte      (rx_byte),
      .rx_status    (rx_status),
      .read_data    (read_data),
      .read_status  (read_status),
      .read_req     (read_req),
      .read_ack     (read_ack),
      .read_overrun (read_overrun)
   );

   uart_tx_serializer #(
      .clks_per_bit (clks_per_bit)
   ) i_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .tx_byte (tx_byte),
      .busy    (busy),
      .done    (done),
      .tx      (tx)
   );

   uart_rx_deserializer #(
      .clks_per_bit (clks_per_bit)
   ) i_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .rx_status  (rx_status)
   );

endmodule

/* verification/uart_link_sva.sv */
`timescale 1ns/10ps

module uart_link_sva (
   input logic       clk,
   input logic       rst_n,
   input logic       tx,
   input logic       cmd_req,
   input logic       cmd_ack,
   input logic       read_req,
   input logic       read_ack,
   input logic [7:0] read_data
);

   int assert_fails = 0;

   // ==========================================================
   // line level and handshake rules
   // ==========================================================

   a_tx_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> tx [*8])
      else begin
         assert_fails++;
         $error("tx left the idle level right after reset");
      end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_ack) |-> cmd_req)
      else begin
         assert_fails++;
         $error("cmd_ack rose while cmd_req was low");
      end

   a_read_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      read_req && !read_ack |=> read_req)
      else begin
         assert_fails++;
         $error("read_req dropped before read_ack");
      end

   a_read_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
      read_req && $past(read_req) |-> $stable(read_data))
      else begin
         assert_fails++;
         $error("read_data changed while read_req was high");
      end

endmodule

bind uart_link uart_link_sva i_sva (
   .clk       (clk),
   .rst_n     (rst_n),
   .tx        (tx),
   .cmd_req   (cmd_req),
   .cmd_ack   (cmd_ack),
   .read_req  (read_req),
   .read_ack  (read_ack),
   .read_data (read_data)
);

/* verification/uart_link_tb.sv */
`timescale 1ns/10ps

module uart_link_tb;

   localparam int clks_per_bit   = 4;
   localparam int cmd_count      = 40;
   localparam int frame_clks     = uart_frame_pkg::frame_bits * clks_per_bit;
   localparam int timeout_cycles = cmd_count * 2 * frame_clks + 3000;

   logic                       clk = 1'b0;
   logic                       rst_n;
   logic [15:0]                cmd_data;
   logic                       cmd_req;
   logic                       cmd_ack;
   logic                       rx;
   logic                       tx;
   logic [7:0]                 read_data;
   uart_frame_pkg::rx_status_e read_status;
   logic                       read_req;
   logic                       read_ack;
   logic                       read_overrun;
   logic                       loop_en;
   logic                       bb_rx;
   logic                       auto_read;
   integer                     seed = 1661;
   string                      test_name = "reset";
   logic [7:0]                 exp_data[$];
   uart_frame_pkg::rx_status_e exp_status[$];
   logic [7:0]                 tx_exp[$];

   always #10 clk = ~clk;

   assign rx = loop_en ? tx : bb_rx;                    // loopback or bit-banged line.

   uart_link #(
      .clks_per_bit (clks_per_bit)
   ) i_uart_link (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_data     (cmd_data),
      .cmd_req      (cmd_req),
      .cmd_ack      (cmd_ack),
      .rx           (rx),
      .tx           (tx),
      .read_data    (read_data),
      .read_status  (read_status),
      .read_req     (read_req),
      .read_ack     (read_ack),
      .read_overrun (read_overrun)
   );

   // ==========================================================
   // error reporting and helpers
   // ==========================================================

   task automatic stop_on_error();
      $display(">>> FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_error(input string what);
      $display("%s in test %s", what, test_name);
      stop_on_error();
   endtask

   task automatic value_error(input string check, input logic [15:0] exp, input logic [15:0] act);
      $display("ERR %s %s expected %h actual %h", test_name, check, exp, act);
      stop_on_error();
   endtask

   task automatic expect_byte(input logic [7:0] data, input uart_frame_pkg::rx_status_e status);
      exp_data.push_back(data);
      exp_status.push_back(status);
   endtask

   task automatic run_command(input logic [15:0] word);
      expect_byte(word[15:8], uart_frame_pkg::rx_ok);
      expect_byte(word[7:0], uart_frame_pkg::rx_ok);
      tx_exp.push_back(word[15:8]);
      tx_exp.push_back(word[7:0]);
      cmd_data = word;
      cmd_req  = 1'b1;
      do begin
         @(negedge clk);
      end while (!cmd_ack);
      assert (tx_exp.size() == 0) else value_error("cmd_ack_after_low_frame", 0, tx_exp.size());
      repeat (2) begin
         @(negedge clk);
         assert (cmd_ack == 1'b1) else value_error("cmd_ack_held", 1, cmd_ack);
      end
      cmd_req = 1'b0;
      @(negedge clk);
      assert (cmd_ack == 1'b0) else value_error("cmd_ack_release", 0, cmd_ack);
   endtask

   task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                             input logic bad_stop, input logic check_byte);
      logic [10:0] frame;
      frame = {1'b0, data, (~^data) ^ bad_parity, ~bad_stop};   // odd parity unless corrupted.
      if (check_byte) begin
         if (bad_stop) begin
            expect_byte(data, uart_frame_pkg::rx_stop_err);
         end else if (bad_parity) begin
            expect_byte(data, uart_frame_pkg::rx_parity_err);
         end else begin
            expect_byte(data, uart_frame_pkg::rx_ok);
         end
      end
      for (int i = uart_frame_pkg::frame_bits - 1; i >= 0; i--) begin
         bb_rx = frame[i];
         repeat (clks_per_bit) @(negedge clk);
      end
      bb_rx = 1'b1;
      repeat (2 * clks_per_bit) @(negedge clk);         // idle gap.
   endtask

   task automatic wait_reads_drained();
      while ((exp_data.size() != 0) || read_req || read_ack) begin
         @(negedge clk);
      end
   endtask

   // ==========================================================
   // background processes
   // ==========================================================

   initial begin : reader
      forever begin
         @(negedge clk);
         if (auto_read && read_req && !read_ack) begin
            assert (exp_data.size() != 0) else report_error("byte received with none expected");
            assert (read_data == exp_data[0]) else value_error("rx_data", exp_data[0], read_data);
            assert (read_status == exp_status[0])
               else value_error("rx_status", exp_status[0], read_status);
            void'(exp_data.pop_front());
            void'(exp_status.pop_front());
            read_ack = 1'b1;
         end else if (auto_read && read_ack && !read_req) begin
            read_ack = 1'b0;
         end
      end
   end

   // samples each tx frame near mid-bit from the start bit on.
   initial begin : frame_monitor
      logic [10:0] bits;
      logic        tx_prev;
      tx_prev = 1'b1;
      forever begin
         @(negedge clk);
         if (loop_en && rst_n && tx_prev && !tx) begin
            for (int i = uart_frame_pkg::frame_bits - 1; i >= 0; i--) begin
               repeat ((i == uart_frame_pkg::frame_bits - 1) ? clks_per_bit / 2 : clks_per_bit)
                  @(negedge clk);
               bits[i] = tx;
            end
            assert (tx_exp.size() != 0) else report_error("frame on tx with no command pending");
            assert (bits[10] == 1'b0) else value_error("tx_start", 0, bits[10]);
            assert (bits[9:2] == tx_exp[0]) else value_error("tx_data", tx_exp[0], bits[9:2]);
            assert (^bits[9:1] == 1'b1) else value_error("tx_parity_odd", 1, ^bits[9:1]);
            assert (bits[0] == 1'b1) else value_error("tx_stop", 1, bits[0]);
            void'(tx_exp.pop_front());
         end
         tx_prev = tx;
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(negedge clk);
         cycles++;
         if (cycles > timeout_cycles) begin
            report_error("timeout, the link stopped making progress");
         end
         if (i_uart_link.i_sva.assert_fails != 0) begin
            report_error("a bound protocol assertion failed");
         end
      end
   end

   // ==========================================================
   // test sequence
   // ==========================================================

   initial begin : main
      logic [15:0] word;
      cmd_data  = '0;
      cmd_req   = 1'b0;
      read_ack  = 1'b0;
      loop_en   = 1'b1;
      bb_rx     = 1'b1;
      auto_read = 1'b1;
      rst_n     = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      assert (tx == 1'b1) else value_error("tx_reset", 1, tx);
      assert (cmd_ack == 1'b0) else value_error("cmd_ack_reset", 0, cmd_ack);
      assert (read_req == 1'b0) else value_error("read_req_reset", 0, read_req);
      assert (read_overrun == 1'b0) else value_error("overrun_reset", 0, read_overrun);
      repeat (20) begin
         @(negedge clk);
         assert (tx == 1'b1) else value_error("tx_idle", 1, tx);
      end

      test_name = "loopback";
      repeat (cmd_count) begin
         word = $random(seed);
         run_command(word);
      end
      wait_reads_drained();
      assert (read_overrun == 1'b0) else value_error("no_overrun", 0, read_overrun);

      test_name = "bad_frames";
      loop_en = 1'b0;
      send_frame(8'ha5, 1'b0, 1'b0, 1'b1);
      send_frame(8'h3c, 1'b1, 1'b0, 1'b1);
      send_frame(8'hc3, 1'b0, 1'b1, 1'b1);
      send_frame(8'h5a, 1'b1, 1'b1, 1'b1);               // stop error wins.
      bb_rx = 1'b0;                                     // one-clock glitch makes a false start.
      @(negedge clk);
      bb_rx = 1'b1;
      repeat (frame_clks) @(negedge clk);
      word = $random(seed);
      send_frame(word[7:0], 1'b0, 1'b0, 1'b1);
      wait_reads_drained();

      test_name = "overrun";
      auto_read = 1'b0;
      word = $random(seed);
      send_frame(word[15:8], 1'b0, 1'b0, 1'b0);
      assert (read_req == 1'b1) else value_error("read_req_first", 1, read_req);
      assert (read_overrun == 1'b0) else value_error("overrun_early", 0, read_overrun);
      send_frame(word[7:0], 1'b0, 1'b0, 1'b0);
      assert (read_overrun == 1'b1) else value_error("overrun_set", 1, read_overrun);
      assert (read_data == word[15:8]) else value_error("first_byte_kept", word[15:8], read_data);
      assert (read_status == uart_frame_pkg::rx_ok)
         else value_error("first_status_kept", uart_frame_pkg::rx_ok, read_status);
      read_ack = 1'b1;
      while (read_req) @(negedge clk);
      read_ack = 1'b0;
      repeat (4) @(negedge clk);
      assert (read_overrun == 1'b1) else value_error("overrun_sticky", 1, read_overrun);

      repeat (10) @(negedge clk);
      if (i_uart_link.i_sva.assert_fails != 0) begin
         report_error("a bound protocol assertion failed");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

/* list.f */
hdl/uart_frame_pkg.sv
hdl/uart_ctrl_pkg.sv
hdl/uart_tx_serializer.sv
hdl/uart_rx_deserializer.sv
hdl/uart_link_ctrl.sv
hdl/uart_link.sv
verification/uart_link_sva.sv
verification/uart_link_tb.sv

/* Bender.yml */
package:
  name: uart_link

sources:
  - files:
      - hdl/uart_frame_pkg.sv
      - hdl/uart_ctrl_pkg.sv
      - hdl/uart_tx_serializer.sv
      - hdl/uart_rx_deserializer.sv
      - hdl/uart_link_ctrl.sv
      - hdl/uart_link.sv
  - target: test
    files:
      - verification/uart_link_sva.sv
      - verification/uart_link_tb.sv
